/* pad_router.f */
+incdir+hdl
hdl/pad_pkg.sv
hdl/llapi_pad_port.sv
hdl/player_slot_mux.sv
hdl/pad_router.sv
test/clock_gen.sv
test/pad_router_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pad router testbench with Verilator.
# The exit status is the simulator's own, nonzero when a check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
	-f pad_router.f \
	--top-module pad_router_tb \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vpad_router_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* test/pad_router_tb.sv */
/*
 * Pad router testbench
 * Directed tests of slot order, layout decode, presence and menu combo
 */
`timescale 1ns/100ps
`include "pad_config.svh"

module pad_router_tb;
	import pad_pkg::*;

	localparam int NUM_TESTS    = 5;
	localparam int LIMIT_CYCLES = 5 + NUM_TESTS * 50;   // Reset plus 50 per test
	localparam logic [31:0] MENU_WORD = 32'h0400_0021;  // Down, start, A

	logic          clk_sys;
	logic          reset;
	llapi_report_t llapi_rep [`PAD_NUM_PORTS];
	md_pad_t       usb_pad [`PAD_NUM_PLAYERS];
	logic          llapi_select;
	logic          swap_ports;
	md_pad_t       player [`PAD_NUM_PLAYERS];
	logic          menu_button;

	md_pad_t usb_val [`PAD_NUM_PLAYERS];      // Values driven on usb_pad
	md_pad_t exp_player [`PAD_NUM_PLAYERS];
	logic    exp_menu;
	integer  seed;

	clock_gen clk_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	pad_router pad_router_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_rep    (llapi_rep),
		.usb_pad      (usb_pad),
		.llapi_select (llapi_select),
		.swap_ports   (swap_ports),
		.player       (player),
		.menu_button  (menu_button)
	);

	////////////////////////////////////////
	// Reference model

	// Adapter word to console pad by the bit positions of each layout
	function automatic md_pad_t decode_adapter_word(input logic [31:0] w, input logic six);
		md_pad_t p;

		p = '0;
		p.y     = w[3];
		p.mode  = w[4];
		p.start = w[5];
		p.z     = w[6];
		if (six) begin
			p.a = w[0];
			p.b = w[1];
			p.x = w[2];
			p.c = w[7];
		end else begin
			p.b = w[0];
			p.c = w[1];
			p.a = w[2];
			p.x = w[7];
		end
		p.right = w[24];
		p.left  = w[25];
		p.down  = w[26];
		p.up    = w[27];
		return p;
	endfunction

	task automatic build_expect(input logic pres0, input logic pres1, input md_pad_t pad0,
		input md_pad_t pad1, input logic swap, input logic menu);
		md_pad_t tmp;

		case ({pres0, pres1})
			2'b11:   exp_player = '{pad0, pad1, usb_val[0], usb_val[1], usb_val[2]};
			2'b10:   exp_player = '{pad0, usb_val[0], usb_val[1], usb_val[2], usb_val[3]};
			2'b01:   exp_player = '{usb_val[0], pad1, usb_val[1], usb_val[2], usb_val[3]};
			default: exp_player = usb_val;
		endcase
		if (swap) begin
			tmp           = exp_player[0];
			exp_player[0] = exp_player[1];
			exp_player[1] = tmp;
		end
		exp_menu = menu;
	endtask

	////////////////////////////////////////
	// Drive, wait and compare

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_pad(input string test, input int slot, input md_pad_t expected,
		input md_pad_t actual);
		if (actual !== expected) begin
			$display("** Error %s: player %0d expected %h, actual %h",
				test, slot, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s: menu_button expected %b, actual %b",
				test, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_outputs(input string test);
		for (int s = 0; s < `PAD_NUM_PLAYERS; s++) begin
			check_pad(test, s, exp_player[s], player[s]);
		end
		check_bit(test, exp_menu, menu_button);
	endtask

	// Two register stages and a sample away from the edge
	task automatic settle();
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic drive_report(input int k, input logic [31:0] btn, input logic [7:0] typ,
		input logic link);
		llapi_rep[k].buttons  <= btn;
		llapi_rep[k].dev_type <= typ;
		llapi_rep[k].en       <= link;
	endtask

	task automatic load_usb_pads();
		integer rnd;

		for (int i = 0; i < `PAD_NUM_PLAYERS; i++) begin
			rnd        = $random(seed);
			usb_val[i] = rnd[11:0];
			usb_pad[i] <= usb_val[i];
		end
	endtask

	////////////////////////////////////////
	// Tests

	// Runs on the edge that releases reset
	task automatic test_reset_idle();
		for (int i = 0; i < `PAD_NUM_PLAYERS; i++) begin
			usb_val[i] = '0;
			usb_pad[i] <= '0;
		end
		for (int k = 0; k < `PAD_NUM_PORTS; k++) begin
			drive_report(k, '0, `PAD_TYPE_NONE, 1'b0);
		end
		llapi_select <= 1'b0;
		swap_ports   <= 1'b0;
		build_expect(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		@(negedge clk_sys);
		check_outputs("reset_clear");   // Still the values loaded in reset
		settle();
		check_outputs("reset_idle");
	endtask

	task automatic test_usb_only();
		@(posedge clk_sys);
		load_usb_pads();
		llapi_select <= 1'b0;
		swap_ports   <= 1'b0;
		settle();
		build_expect(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		check_outputs("usb_only");
		@(posedge clk_sys);
		swap_ports <= 1'b1;
		settle();
		build_expect(1'b0, 1'b0, '0, '0, 1'b1, 1'b0);
		check_outputs("usb_only_swap");
		@(posedge clk_sys);
		swap_ports <= 1'b0;
	endtask

	// Port 1 must not have seen a button since reset
	task automatic test_std_view_and_sticky();
		logic [31:0] w1;
		logic [31:0] w2;

		w1 = 32'h0900_00c4;
		w2 = 32'h0600_001b;
		@(posedge clk_sys);
		load_usb_pads();
		llapi_select <= 1'b1;
		drive_report(0, '0, `PAD_TYPE_NONE, 1'b0);
		drive_report(1, '0, `PAD_TYPE_NONE, 1'b1);
		settle();
		build_expect(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		check_outputs("type0_no_press");
		@(posedge clk_sys);
		drive_report(1, w1, `PAD_TYPE_NONE, 1'b1);
		settle();
		build_expect(1'b0, 1'b1, '0, decode_adapter_word(w1, 1'b0), 1'b0, 1'b0);
		check_outputs("type0_pressed");
		@(posedge clk_sys);
		drive_report(1, '0, `PAD_TYPE_NONE, 1'b1);
		settle();
		build_expect(1'b0, 1'b1, '0, '0, 1'b0, 1'b0);
		check_outputs("type0_released");
		@(posedge clk_sys);
		drive_report(1, '0, `PAD_TYPE_NONE, 1'b0);
		drive_report(0, w2, 8'd5, 1'b1);   // Type 5 is not a six-button code
		settle();
		build_expect(1'b1, 1'b0, decode_adapter_word(w2, 1'b0), '0, 1'b0, 1'b0);
		check_outputs("type5_std_view");
	endtask

	task automatic test_single_port_six();
		logic [31:0] w3;
		logic [31:0] w4;

		w3 = 32'h0a00_00d6;
		w4 = 32'h0500_004d;
		@(posedge clk_sys);
		load_usb_pads();
		drive_report(0, w3, 8'd20, 1'b1);
		drive_report(1, '0, 8'd20, 1'b0);
		settle();
		build_expect(1'b1, 1'b0, decode_adapter_word(w3, 1'b1), '0, 1'b0, 1'b0);
		check_outputs("port0_six");
		@(posedge clk_sys);
		drive_report(0, '0, 8'd20, 1'b0);
		drive_report(1, w4, 8'd20, 1'b1);
		settle();
		build_expect(1'b0, 1'b1, '0, decode_adapter_word(w4, 1'b1), 1'b0, 1'b0);
		check_outputs("port1_six");
	endtask

	task automatic test_both_ports_menu();
		logic [31:0] w3;
		logic [31:0] w4;

		w3 = 32'h0a00_00d6;
		w4 = 32'h0500_004d;
		@(posedge clk_sys);
		load_usb_pads();
		drive_report(0, w3, 8'd20, 1'b1);
		drive_report(1, w4, 8'd20, 1'b1);
		settle();
		build_expect(1'b1, 1'b1, decode_adapter_word(w3, 1'b1),
			decode_adapter_word(w4, 1'b1), 1'b0, 1'b0);
		check_outputs("both_ports");
		@(posedge clk_sys);
		llapi_select <= 1'b0;   // Combo still counts
		drive_report(0, '0, 8'd20, 1'b1);
		drive_report(1, MENU_WORD, 8'd20, 1'b1);
		settle();
		build_expect(1'b0, 1'b0, '0, '0, 1'b0, 1'b1);
		check_outputs("menu_port1");
		@(posedge clk_sys);
		drive_report(0, MENU_WORD, 8'd20, 1'b1);
		drive_report(1, '0, 8'd20, 1'b1);
		settle();
		build_expect(1'b0, 1'b0, '0, '0, 1'b0, 1'b1);
		check_outputs("menu_port0");
		@(posedge clk_sys);
		drive_report(0, '0, 8'd20, 1'b1);
		settle();
		build_expect(1'b0, 1'b0, '0, '0, 1'b0, 1'b0);
		check_outputs("menu_released");
	endtask

	////////////////////////////////////////
	// Sequence and watchdog

	initial begin
		seed = 25;
		// Busy inputs while reset is held
		for (int i = 0; i < `PAD_NUM_PLAYERS; i++) begin
			usb_val[i] = '1;
			usb_pad[i] <= usb_val[i];
		end
		for (int k = 0; k < `PAD_NUM_PORTS; k++) begin
			drive_report(k, MENU_WORD, 8'd20, 1'b1);
		end
		llapi_select <= 1'b1;
		swap_ports   <= 1'b1;
		@(negedge reset);
		test_reset_idle();
		test_usb_only();
		test_std_view_and_sticky();   // Before any press on port 1
		test_single_port_six();
		test_both_ports_menu();
		$display("TESTS PASSED");
		$finish;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk_sys);
		$display("Watchdog timeout, the tests did not finish in %0d cycles", LIMIT_CYCLES);
		$display("TESTS FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* test/clock_gen.sv */
/*
 * Testbench clock and reset, 8 ns period, reset high for 5 cycles
 */
`timescale 1ns/100ps

module clock_gen (
	output logic clk_sys,
	output logic reset
);
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		reset <= 1'b1;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;   // Released on a rising edge
	end

endmodule

/* hdl/pad_router.sv */
/*
 * Pad router top
 * Adapter ports in parallel, drained by the player slot multiplexer
 */
`timescale 1ns/100ps
`include "pad_config.svh"

module pad_router (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pad_pkg::llapi_report_t llapi_rep [`PAD_NUM_PORTS],
	input  pad_pkg::md_pad_t       usb_pad [`PAD_NUM_PLAYERS],
	input  logic                   llapi_select,
	input  logic                   swap_ports,
	output pad_pkg::md_pad_t       player [`PAD_NUM_PLAYERS],
	output logic                   menu_button
);
	import pad_pkg::*;

	port_pad_t port_out [`PAD_NUM_PORTS];  // One result per adapter

	////////////////////////////////////////
	// Adapter ports

	generate
		for (genvar k = 0; k < `PAD_NUM_PORTS; k++) begin : g_port
			llapi_pad_port port_i (
				.clk_sys      (clk_sys),
				.reset        (reset),
				.rep          (llapi_rep[k]),
				.llapi_select (llapi_select),
				.port_out     (port_out[k])
			);
		end
	endgenerate

	////////////////////////////////////////
	// Slot assignment

	// Second register stage
	player_slot_mux mux_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.port_out    (port_out),
		.usb_pad     (usb_pad),
		.swap_ports  (swap_ports),
		.player      (player),
		.menu_button (menu_button)
	);

endmodule

/* hdl/player_slot_mux.sv */
/*
 * Player slot multiplexer
 * Places adapter pads in their own slots, moves USB pads to the
 * free ones, applies the player 1/2 swap and merges menu requests
 */
`timescale 1ns/100ps
`include "pad_config.svh"

module player_slot_mux (
	input  logic               clk_sys,
	input  logic               reset,
	input  pad_pkg::port_pad_t port_out [`PAD_NUM_PORTS],
	input  pad_pkg::md_pad_t   usb_pad [`PAD_NUM_PLAYERS],
	input  logic               swap_ports,
	output pad_pkg::md_pad_t   player [`PAD_NUM_PLAYERS],
	output logic               menu_button
);
	import pad_pkg::*;

	localparam int IDX_W = $clog2(`PAD_NUM_PLAYERS + 1);

	md_pad_t slot    [`PAD_NUM_PLAYERS];   // Before the swap
	md_pad_t slot_sw [`PAD_NUM_PLAYERS];
	logic    menu_any;

	////////////////////////////////////////
	// Slot assignment

	// Adapter k owns slot k when present, USB pads fill the rest in order
	always_comb begin
		logic [IDX_W-1:0] usb_idx;

		usb_idx = '0;
		for (int s = 0; s < `PAD_NUM_PORTS; s++) begin
			if (port_out[s].present) begin
				slot[s] = port_out[s].pad;
			end else begin
				slot[s] = usb_pad[usb_idx];
				usb_idx = usb_idx + 1'b1;
			end
		end
		for (int s = `PAD_NUM_PORTS; s < `PAD_NUM_PLAYERS; s++) begin
			slot[s] = usb_pad[usb_idx];
			usb_idx = usb_idx + 1'b1;
		end
	end

	always_comb begin
		slot_sw = slot;
		if (swap_ports) begin
			slot_sw[0] = slot[1];   // Player 1/2 swap
			slot_sw[1] = slot[0];
		end
	end

	// Any port may call the menu
	always_comb begin
		menu_any = 1'b0;
		for (int p = 0; p < `PAD_NUM_PORTS; p++) begin
			menu_any = menu_any | port_out[p].menu;
		end
	end

	////////////////////////////////////////
	// Output register

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			player      <= '{default: '0};
			menu_button <= 1'b0;
		end else begin
			player      <= slot_sw;
			menu_button <= menu_any;
		end
	end

	// Console must see idle pads straight after reset
	generate
		for (genvar s = 0; s < `PAD_NUM_PLAYERS; s++) begin : g_rst_chk
			a_player_clear: assert property (@(posedge clk_sys)
				reset |=> player[s] == '0);
		end
	endgenerate

endmodule

/* hdl/llapi_pad_port.sv */
/*
 * Adapter port
 * Decodes one adapter report into a console pad word and
 * flags controller presence and the menu button combo
 */
`timescale 1ns/100ps
`include "pad_config.svh"

module llapi_pad_port (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pad_pkg::llapi_report_t rep,
	input  logic                   llapi_select,
	output pad_pkg::port_pad_t     port_out
);
	import pad_pkg::*;

	logic    six_layout;
	logic    id_known;
	logic    any_btn;
	logic    pressed;     // Sticky flag of any button seen since reset
	md_pad_t pad_dec;
	logic    menu_combo;

	////////////////////////////////////////
	// Layout and identity

	always_comb begin
		case (rep.dev_type)
			`PAD_TYPE_SIX_0,
			`PAD_TYPE_SIX_1,
			`PAD_TYPE_SIX_2,
			`PAD_TYPE_SIX_3,
			`PAD_TYPE_SIX_4,
			`PAD_TYPE_SIX_5: six_layout = 1'b1;
			default:         six_layout = 1'b0;
		endcase
	end

	// Type 0 can still be a real pad, so a button press also counts
	assign id_known = (rep.dev_type != `PAD_TYPE_NONE) &&
		(rep.dev_type != `PAD_TYPE_ABSENT);
	assign any_btn  = |rep.buttons;

	////////////////////////////////////////
	// Button decode

	always_comb begin
		if (six_layout) begin
			pad_dec.x     = rep.buttons.six_btn.x;
			pad_dec.c     = rep.buttons.six_btn.c;
			pad_dec.b     = rep.buttons.six_btn.b;
			pad_dec.a     = rep.buttons.six_btn.a;
		end else begin
			pad_dec.x     = rep.buttons.std_btn.x;
			pad_dec.c     = rep.buttons.std_btn.c;
			pad_dec.b     = rep.buttons.std_btn.b;
			pad_dec.a     = rep.buttons.std_btn.a;
		end
		// Face buttons shared by both layouts
		pad_dec.z     = rep.buttons.six_btn.z;
		pad_dec.y     = rep.buttons.six_btn.y;
		pad_dec.mode  = rep.buttons.six_btn.mode;
		pad_dec.start = rep.buttons.six_btn.start;
		// D-pad sits in the same bits for every layout
		pad_dec.up    = rep.buttons.six_btn.up;
		pad_dec.down  = rep.buttons.six_btn.down;
		pad_dec.left  = rep.buttons.six_btn.left;
		pad_dec.right = rep.buttons.six_btn.right;
	end

	// Menu combo on raw bits for every layout
	assign menu_combo = rep.buttons.six_btn.down &
		rep.buttons.six_btn.start & rep.buttons.six_btn.a;

	////////////////////////////////////////
	// Output register

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed  <= 1'b0;
			port_out <= '0;
		end else begin
			if (any_btn) begin
				pressed <= 1'b1;
			end
			port_out.pad     <= pad_dec;
			// A press in this cycle counts as well
			port_out.present <= rep.en && llapi_select &&
				(id_known || pressed || any_btn);
			port_out.menu    <= menu_combo; // Not gated by select
		end
	end

	// With the link up and the type code unchanged, presence holds
	a_present_holds: assert property (@(posedge clk_sys) disable iff (reset)
		port_out.present && rep.en && llapi_select && $stable(rep.dev_type)
		|=> port_out.present);

endmodule

/* hdl/pad_pkg.sv */
/*
 * Pad router types
 * Console pad word, the two views of the adapter button word,
 * the adapter report and the result of one adapter port
 */
package pad_pkg;

	// Console pad word, top bit first
	typedef struct packed {
		logic z;
		logic y;
		logic x;
		logic mode;
		logic start;
		logic c;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} md_pad_t;

	// Adapter word as seen by six-button pads
	typedef struct packed {
		logic [3:0]  rsvd_hi;
		logic        up;        // Bit 27
		logic        down;
		logic        left;
		logic        right;     // Bit 24
		logic [15:0] rsvd_mid;  // Unused here
		logic        c;         // Bit 7
		logic        z;
		logic        start;
		logic        mode;
		logic        y;
		logic        x;
		logic        b;
		logic        a;         // Bit 0
	} six_btn_t;

	// Same word for three-button and other pads
	typedef struct packed {
		logic [3:0]  rsvd_hi;
		logic        up;
		logic        down;
		logic        left;
		logic        right;
		logic [15:0] rsvd_mid;
		logic        x;         // Bit 7
		logic        z;
		logic        start;
		logic        mode;
		logic        y;
		logic        a;
		logic        c;
		logic        b;         // Bit 0
	} std_btn_t;

	typedef union packed {
		six_btn_t six_btn;
		std_btn_t std_btn;
	} llapi_btn_u;

	// One report from the adapter front end
	typedef struct packed {
		llapi_btn_u buttons;
		logic [7:0] dev_type;   // Adapter type code
		logic       en;         // Adapter link up
	} llapi_report_t;

	// Result of one adapter port
	typedef struct packed {
		md_pad_t pad;
		logic    present;
		logic    menu;      // Down + start + A held
	} port_pad_t;

endpackage

/* hdl/pad_config.svh */
/*
 * Pad router configuration
 * Port and player counts, adapter type codes for layout and presence
 */
`ifndef PAD_CONFIG_SVH
`define PAD_CONFIG_SVH

////////////////////////////////////////
// Port counts

`define PAD_NUM_PORTS   2   // Low-latency adapter ports
`define PAD_NUM_PLAYERS 5   // Player slots, also the USB pad count

////////////////////////////////////////
// Adapter type codes with the six-button layout

`define PAD_TYPE_SIX_0  8'd3
`define PAD_TYPE_SIX_1  8'd8
`define PAD_TYPE_SIX_2  8'd11
`define PAD_TYPE_SIX_3  8'd20
`define PAD_TYPE_SIX_4  8'd21
`define PAD_TYPE_SIX_5  8'd54

////////////////////////////////////////
// Codes that identify no controller

// Atari stick or empty port, present only once a button shows up
`define PAD_TYPE_NONE   8'd0
`define PAD_TYPE_ABSENT 8'd255   // Adapter reports nothing attached

`endif
